/* src/agg_pkg.sv */
// ----------------------------------------------------------
// widths, depths, credit counts and the MAC constant
// shared beat and lane types of the aggregation datapath
// ----------------------------------------------------------
package agg_pkg;

  // stream geometry
  localparam int NUM_PORTS = 4;
  localparam int DATA_W    = 64;
  localparam int KEEP_W    = DATA_W / 8;
  localparam int LANE_W    = 32;             // one aggregation element
  localparam int NUM_LANES = DATA_W / LANE_W;

  // header beats ahead of the payload, header ends at bit 320
  localparam int HDR_WORDS = 5;

  // destination MAC sits in bits 47:0 of header beat 0
  localparam int                MAC_W        = 48;
  localparam logic [MAC_W-1:0]  NEW_DEST_MAC = {MAC_W{1'b1}};

  // buffering and credits
  localparam int FIFO_DEPTH  = 16;  // per input port, also initial sender credits
  localparam int RES_DEPTH   = 8;   // result fifo, also align to egress credits
  localparam int OUT_CREDITS = 4;   // granted by downstream after reset
  localparam int CNT_W       = 5;   // holds counts up to 16

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [KEEP_W-1:0] keep_t;
  typedef logic [LANE_W-1:0] lane_t;

  // one stored beat, 73 bits
  typedef struct packed {
    logic  last;
    keep_t keep;
    word_t data;
  } beat_t;

endpackage

/* src/credit_fifo.sv */
// ----------------------------------------------------------
// synchronous fall-through fifo with a type-parameter payload
// ----------------------------------------------------------
module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 16     // power of two, pointers wrap naturally
) (
  input  logic     axis_aclk,
  input  logic     axis_resetn,
  input  logic     wr_en,
  input  payload_t wr_payload,
  input  logic     rd_en,
  output payload_t rd_payload,
  output logic     empty,
  output logic     full
);

  payload_t                  mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]  wr_ptr;
  logic [$clog2(DEPTH)-1:0]  rd_ptr;
  logic [agg_pkg::CNT_W-1:0] fill;

  assign rd_payload = mem[rd_ptr];  // head visible while not empty
  assign empty      = (fill == '0);
  assign full       = (fill == agg_pkg::CNT_W'(DEPTH));

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_payload;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;        // idle or write and read together
      endcase
    end
  end

  // the credit loop around this fifo must keep both of these from happening
  a_no_overflow : assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    wr_en |-> !full)
    else $error("credit_fifo written while full");

  a_no_underflow : assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    rd_en |-> !empty)
    else $error("credit_fifo read while empty");

endmodule

/* src/port_align.sv */
// ----------------------------------------------------------
// per-port input fifos with lockstep pop across all ports
// header beat tracking and destination MAC rewrite
// ----------------------------------------------------------
module port_align (
  input  logic           axis_aclk,
  input  logic           axis_resetn,
  input  agg_pkg::word_t s_data  [agg_pkg::NUM_PORTS],
  input  agg_pkg::keep_t s_keep  [agg_pkg::NUM_PORTS],
  input  logic           s_last  [agg_pkg::NUM_PORTS],
  input  logic           s_valid [agg_pkg::NUM_PORTS],
  input  logic           res_credit,
  output logic           s_credit [agg_pkg::NUM_PORTS],
  output logic           al_valid,
  output logic           al_header,
  output agg_pkg::word_t al_data [agg_pkg::NUM_PORTS],
  output agg_pkg::keep_t al_keep,
  output logic           al_last
);

  agg_pkg::beat_t                in_beat [agg_pkg::NUM_PORTS];
  agg_pkg::beat_t                head    [agg_pkg::NUM_PORTS];
  logic [agg_pkg::NUM_PORTS-1:0] fifo_empty;
  logic [agg_pkg::NUM_PORTS-1:0] fifo_full;
  logic [agg_pkg::NUM_PORTS-1:0] head_last;
  logic [agg_pkg::CNT_W-1:0]     res_cnt;    // free slots in the result fifo
  logic [agg_pkg::CNT_W-1:0]     beat_cnt;   // saturates at HDR_WORDS
  logic                          pop;
  agg_pkg::word_t                port0_word;

  for (genvar p = 0; p < agg_pkg::NUM_PORTS; p++) begin : g_port
    assign in_beat[p] = '{last: s_last[p], keep: s_keep[p], data: s_data[p]};

    credit_fifo #(
      .payload_t (agg_pkg::beat_t),
      .DEPTH     (agg_pkg::FIFO_DEPTH)
    ) in_fifo_i (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .wr_en       (s_valid[p]),
      .wr_payload  (in_beat[p]),
      .rd_en       (pop),
      .rd_payload  (head[p]),
      .empty       (fifo_empty[p]),
      .full        (fifo_full[p])
    );

    assign s_credit[p]  = pop;   // one credit back per popped entry
    assign head_last[p] = head[p].last;

    // sender spent a credit it did not hold
    a_sender_credit : assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      s_valid[p] |-> !fifo_full[p])
      else $error("port %0d sent a beat without a credit", p);
  end

  // all ports present and room downstream
  assign pop = (fifo_empty == '0) && (res_cnt != '0);

  always_comb begin
    port0_word = head[0].data;
    if (beat_cnt == '0) begin
      port0_word[agg_pkg::MAC_W-1:0] = agg_pkg::NEW_DEST_MAC;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      res_cnt  <= agg_pkg::CNT_W'(agg_pkg::RES_DEPTH);
      beat_cnt <= '0;
      al_valid <= 1'b0;
    end else begin
      res_cnt  <= res_cnt - agg_pkg::CNT_W'(pop) + agg_pkg::CNT_W'(res_credit);
      al_valid <= pop;
      if (pop) begin
        if (head[0].last) begin
          beat_cnt <= '0;           // next beat opens a new packet
        end else if (beat_cnt != agg_pkg::CNT_W'(agg_pkg::HDR_WORDS)) begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (pop) begin
      al_header  <= (beat_cnt < agg_pkg::CNT_W'(agg_pkg::HDR_WORDS));
      al_keep    <= head[0].keep;
      al_last    <= head[0].last;
      al_data[0] <= port0_word;
      for (int p = 1; p < agg_pkg::NUM_PORTS; p++) begin
        al_data[p] <= head[p].data;
      end
    end
  end

  // senders must keep their packets the same length
  a_last_agree : assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    pop |-> (head_last == '0 || head_last == '1))
    else $error("ports disagree on last for an aligned beat");

endmodule

/* src/lane_adder.sv */
// ----------------------------------------------------------
// one 32-bit lane: header pass-through or byte-swapped sum
// ----------------------------------------------------------
module lane_adder (
  input  logic           axis_aclk,
  input  logic           axis_resetn,
  input  logic           al_valid,
  input  logic           al_header,
  input  agg_pkg::lane_t port_lane [agg_pkg::NUM_PORTS],
  output logic           sum_valid,
  output agg_pkg::lane_t sum_lane
);

  agg_pkg::lane_t swapped [agg_pkg::NUM_PORTS];  // host byte order
  agg_pkg::lane_t total;
  agg_pkg::lane_t total_net;
  agg_pkg::lane_t next_lane;

  // lanes arrive in network byte order
  always_comb begin
    for (int p = 0; p < agg_pkg::NUM_PORTS; p++) begin
      swapped[p] = {<<8{port_lane[p]}};
    end
  end

  always_comb begin
    total = '0;
    for (int p = 0; p < agg_pkg::NUM_PORTS; p++) begin
      total = total + swapped[p];   // wraps modulo 2^32
    end
  end

  assign total_net = {<<8{total}};
  assign next_lane = al_header ? port_lane[0] : total_net;

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= al_valid;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (al_valid) begin
      sum_lane <= next_lane;
    end
  end

endmodule

/* src/egress_sequencer.sv */
// ----------------------------------------------------------
// result fifo and output stage under downstream credits
// ----------------------------------------------------------
module egress_sequencer (
  input  logic                           axis_aclk,
  input  logic                           axis_resetn,
  input  logic [agg_pkg::NUM_LANES-1:0]  sum_valid,   // bit 0 writes the fifo
  input  agg_pkg::lane_t                 sum_lane [agg_pkg::NUM_LANES],
  input  agg_pkg::keep_t                 al_keep,
  input  logic                           al_last,
  input  logic                           m_credit,
  output agg_pkg::word_t                 m_data,
  output agg_pkg::keep_t                 m_keep,
  output logic                           m_last,
  output logic                           m_valid,
  output logic                           res_credit
);

  agg_pkg::keep_t            keep_d;
  logic                      last_d;
  agg_pkg::beat_t            res_in;
  agg_pkg::beat_t            res_head;
  logic                      res_empty;
  logic                      pop;
  logic [agg_pkg::CNT_W-1:0] out_cnt;   // includes the credit of a beat on m_valid

  // keep and last ride one stage to line up with the lane registers
  always_ff @(posedge axis_aclk) begin
    keep_d <= al_keep;
    last_d <= al_last;
  end

  always_comb begin
    res_in.last = last_d;
    res_in.keep = keep_d;
    res_in.data = '0;
    for (int l = 0; l < agg_pkg::NUM_LANES; l++) begin
      res_in.data[l*agg_pkg::LANE_W +: agg_pkg::LANE_W] = sum_lane[l];
    end
  end

  credit_fifo #(
    .payload_t (agg_pkg::beat_t),
    .DEPTH     (agg_pkg::RES_DEPTH)
  ) res_fifo_i (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .wr_en       (sum_valid[0]),
    .wr_payload  (res_in),
    .rd_en       (pop),
    .rd_payload  (res_head),
    .empty       (res_empty),
    .full        ()
  );

  // a credit left over after the beat now on the output
  assign pop        = !res_empty && (out_cnt > agg_pkg::CNT_W'(m_valid));
  assign res_credit = pop;

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      out_cnt <= agg_pkg::CNT_W'(agg_pkg::OUT_CREDITS);
      m_valid <= 1'b0;
    end else begin
      out_cnt <= out_cnt - agg_pkg::CNT_W'(m_valid) + agg_pkg::CNT_W'(m_credit);
      m_valid <= pop;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (pop) begin
      m_data <= res_head.data;
      m_keep <= res_head.keep;
      m_last <= res_head.last;
    end
  end

  // lanes are fed the same valid and must stay in step
  a_lanes_agree : assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    sum_valid == '0 || sum_valid == '1)
    else $error("lane adders out of step");

  // downstream returns no more than it granted
  a_credit_bound : assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    out_cnt <= agg_pkg::CNT_W'(agg_pkg::OUT_CREDITS))
    else $error("output credit count above OUT_CREDITS");

endmodule

/* src/agg_datapath.sv */
// ----------------------------------------------------------
// top level: aligner, lane adders and egress sequencer
// ----------------------------------------------------------
module agg_datapath (
  input  logic           axis_aclk,
  input  logic           axis_resetn,
  input  agg_pkg::word_t s_data  [agg_pkg::NUM_PORTS],
  input  agg_pkg::keep_t s_keep  [agg_pkg::NUM_PORTS],
  input  logic           s_last  [agg_pkg::NUM_PORTS],
  input  logic           s_valid [agg_pkg::NUM_PORTS],
  input  logic           m_credit,
  output logic           s_credit [agg_pkg::NUM_PORTS],
  output agg_pkg::word_t m_data,
  output agg_pkg::keep_t m_keep,
  output logic           m_last,
  output logic           m_valid
);

  logic                          al_valid;
  logic                          al_header;
  agg_pkg::word_t                al_data [agg_pkg::NUM_PORTS];
  agg_pkg::keep_t                al_keep;
  logic                          al_last;
  logic [agg_pkg::NUM_LANES-1:0] sum_valid;
  agg_pkg::lane_t                sum_lane [agg_pkg::NUM_LANES];
  logic                          res_credit;

  port_align port_align_i (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .s_data      (s_data),
    .s_keep      (s_keep),
    .s_last      (s_last),
    .s_valid     (s_valid),
    .res_credit  (res_credit),
    .s_credit    (s_credit),
    .al_valid    (al_valid),
    .al_header   (al_header),
    .al_data     (al_data),
    .al_keep     (al_keep),
    .al_last     (al_last)
  );

  for (genvar l = 0; l < agg_pkg::NUM_LANES; l++) begin : g_lane
    agg_pkg::lane_t port_lane [agg_pkg::NUM_PORTS];   // lane l of every port

    for (genvar p = 0; p < agg_pkg::NUM_PORTS; p++) begin : g_slice
      assign port_lane[p] = al_data[p][l*agg_pkg::LANE_W +: agg_pkg::LANE_W];
    end

    lane_adder lane_adder_i (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .al_valid    (al_valid),
      .al_header   (al_header),
      .port_lane   (port_lane),
      .sum_valid   (sum_valid[l]),
      .sum_lane    (sum_lane[l])
    );
  end

  egress_sequencer egress_sequencer_i (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .sum_valid   (sum_valid),
    .sum_lane    (sum_lane),
    .al_keep     (al_keep),
    .al_last     (al_last),
    .m_credit    (m_credit),
    .m_data      (m_data),
    .m_keep      (m_keep),
    .m_last      (m_last),
    .m_valid     (m_valid),
    .res_credit  (res_credit)
  );

endmodule

/* verif/agg_datapath_tb.sv */
// ----------------------------------------------------------
// testbench: LFSR stimulus, credit-tracking port senders,
// downstream credit model, reference model and compare tasks
// ----------------------------------------------------------
module agg_datapath_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROUNDS  = 40;
  localparam int RUN_LIMIT   = 50000;  // cycles for all rounds
  localparam int DRAIN_LIMIT = 200;

  logic           axis_aclk;
  logic           axis_resetn;
  agg_pkg::word_t s_data   [agg_pkg::NUM_PORTS];
  agg_pkg::keep_t s_keep   [agg_pkg::NUM_PORTS];
  logic           s_last   [agg_pkg::NUM_PORTS];
  logic           s_valid  [agg_pkg::NUM_PORTS];
  logic           s_credit [agg_pkg::NUM_PORTS];
  logic           m_credit;
  agg_pkg::word_t m_data;
  agg_pkg::keep_t m_keep;
  logic           m_last;
  logic           m_valid;

  logic [31:0]    lfsr_state = 32'd89595;
  agg_pkg::beat_t port_q [agg_pkg::NUM_PORTS][$];  // beats still to send
  agg_pkg::beat_t exp_q [$];
  int             sent     [agg_pkg::NUM_PORTS];
  int             returned [agg_pkg::NUM_PORTS];
  int             gap      [agg_pkg::NUM_PORTS];
  int             out_beats     = 0;
  int             credits_given = 0;   // m_credit pulses so far
  int             stall         = 0;

  agg_datapath agg_datapath_i (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .s_data      (s_data),
    .s_keep      (s_keep),
    .s_last      (s_last),
    .s_valid     (s_valid),
    .m_credit    (m_credit),
    .s_credit    (s_credit),
    .m_data      (m_data),
    .m_keep      (m_keep),
    .m_last      (m_last),
    .m_valid     (m_valid)
  );

  initial begin
    axis_aclk = 1'b0;
    forever #5 axis_aclk = ~axis_aclk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};  // one step per bit
    end
    return v;
  endfunction

  function automatic agg_pkg::lane_t byte_swap(input agg_pkg::lane_t v);
    agg_pkg::lane_t r;
    for (int i = 0; i < agg_pkg::LANE_W / 8; i++) begin
      r[8*i +: 8] = v[agg_pkg::LANE_W-8-8*i +: 8];
    end
    return r;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input agg_pkg::word_t got, input agg_pkg::word_t want,
                            input string what);
    if (got !== want) begin
      abort_run($sformatf("Fail at %0t: %s data %h, expected %h", $time, what, got, want));
    end
  endtask

  task automatic check_keep(input agg_pkg::keep_t got, input agg_pkg::keep_t want,
                            input string what);
    if (got !== want) begin
      abort_run($sformatf("Fail at %0t: %s keep %h, expected %h", $time, what, got, want));
    end
  endtask

  task automatic check_last(input logic got, input logic want, input string what);
    if (got !== want) begin
      abort_run($sformatf("Fail at %0t: %s last %b, expected %b", $time, what, got, want));
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, want));
    end
  endtask

  // per round: same length on every port, expected beats from port 0
  task automatic build_rounds();
    agg_pkg::beat_t cur [agg_pkg::NUM_PORTS];
    agg_pkg::beat_t want;
    agg_pkg::lane_t sum;
    int             len;
    for (int r = 0; r < NUM_ROUNDS; r++) begin
      len = agg_pkg::HDR_WORDS + 1 + int'(rand_bits(2));
      for (int b = 0; b < len; b++) begin
        for (int p = 0; p < agg_pkg::NUM_PORTS; p++) begin
          cur[p].data = agg_pkg::word_t'(rand_bits(agg_pkg::DATA_W));
          cur[p].keep = agg_pkg::keep_t'(rand_bits(agg_pkg::KEEP_W));
          cur[p].last = (b == len - 1);
          port_q[p].push_back(cur[p]);
        end
        want = cur[0];
        if (b == 0) begin
          want.data[agg_pkg::MAC_W-1:0] = agg_pkg::NEW_DEST_MAC;
        end else if (b >= agg_pkg::HDR_WORDS) begin
          for (int l = 0; l < agg_pkg::NUM_LANES; l++) begin
            sum = '0;
            for (int p = 0; p < agg_pkg::NUM_PORTS; p++) begin
              sum = sum + byte_swap(cur[p].data[l*agg_pkg::LANE_W +: agg_pkg::LANE_W]);
            end
            want.data[l*agg_pkg::LANE_W +: agg_pkg::LANE_W] = byte_swap(sum);
          end
        end
        exp_q.push_back(want);
      end
    end
  endtask

  function automatic logic all_sent();
    for (int p = 0; p < agg_pkg::NUM_PORTS; p++) begin
      if (port_q[p].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic logic credits_back();
    for (int p = 0; p < agg_pkg::NUM_PORTS; p++) begin
      if (returned[p] != sent[p]) return 1'b0;
    end
    return 1'b1;
  endfunction

  // one clock of senders and downstream credit return
  task automatic drive_cycle();
    agg_pkg::beat_t b;
    @(posedge axis_aclk);
    for (int p = 0; p < agg_pkg::NUM_PORTS; p++) begin
      if (gap[p] != 0) begin
        gap[p]--;
        s_valid[p] <= 1'b0;
      end else if (port_q[p].size() != 0 && sent[p] - returned[p] < agg_pkg::FIFO_DEPTH) begin
        b = port_q[p].pop_front();
        s_data[p]  <= b.data;
        s_keep[p]  <= b.keep;
        s_last[p]  <= b.last;
        s_valid[p] <= 1'b1;
        sent[p]++;
        if (rand_bits(2) == 64'd0) gap[p] = int'(rand_bits(3));  // idle gap
      end else begin
        s_valid[p] <= 1'b0;
      end
    end
    if (stall != 0) begin
      stall--;
      m_credit <= 1'b0;
    end else if (rand_bits(6) == 64'd0) begin
      stall = 16 + int'(rand_bits(6));   // long credit drought
      m_credit <= 1'b0;
    end else if (credits_given < out_beats && rand_bits(1) == 64'd1) begin
      m_credit <= 1'b1;   // only for beats already taken
      credits_given++;
    end else begin
      m_credit <= 1'b0;
    end
  endtask

  always @(negedge axis_aclk) begin : watch_outputs
    agg_pkg::beat_t want;
    if (axis_resetn === 1'b1) begin
      for (int p = 0; p < agg_pkg::NUM_PORTS; p++) begin
        if (s_credit[p] === 1'b1) begin
          returned[p]++;
          if (returned[p] > sent[p]) begin
            abort_run($sformatf("Fail at %0t: port %0d got %0d credits for %0d beats",
                                $time, p, returned[p], sent[p]));
          end
        end
      end
      if (m_valid === 1'b1) begin
        out_beats++;
        if (out_beats > agg_pkg::OUT_CREDITS + credits_given) begin
          abort_run($sformatf("Fail at %0t: %0d output beats exceed granted credits",
                              $time, out_beats));
        end
        if (exp_q.size() == 0) begin
          abort_run("Output produced a beat after all expected beats were received");
        end
        want = exp_q.pop_front();
        check_data(m_data, want.data, $sformatf("output beat %0d", out_beats));
        check_keep(m_keep, want.keep, $sformatf("output beat %0d", out_beats));
        check_last(m_last, want.last, $sformatf("output beat %0d", out_beats));
      end
    end
  end

  initial begin : main_flow
    int cycles;
    axis_resetn <= 1'b0;
    m_credit    <= 1'b0;
    for (int p = 0; p < agg_pkg::NUM_PORTS; p++) begin
      s_data[p]   <= '0;
      s_keep[p]   <= '0;
      s_last[p]   <= 1'b0;
      s_valid[p]  <= 1'b0;
      sent[p]     = 0;
      returned[p] = 0;
      gap[p]      = 0;
    end
    build_rounds();

    repeat (3) @(posedge axis_aclk);
    @(negedge axis_aclk);
    check_flag(m_valid, 1'b0, "m_valid in reset");
    for (int p = 0; p < agg_pkg::NUM_PORTS; p++) begin
      check_flag(s_credit[p], 1'b0, $sformatf("s_credit[%0d] in reset", p));
    end
    @(posedge axis_aclk);
    axis_resetn <= 1'b1;   // fourth reset edge

    cycles = 0;
    while (!all_sent() || exp_q.size() != 0) begin
      drive_cycle();
      cycles++;
      if (cycles > RUN_LIMIT) begin
        if (!all_sent()) begin
          abort_run("Timeout: input senders stalled with beats still to send");
        end else begin
          abort_run("Timeout: output stopped before all expected beats arrived");
        end
      end
    end

    cycles = 0;
    while (!credits_back()) begin
      drive_cycle();
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        abort_run("Timeout: input ports never got back all of their credits");
      end
    end

    repeat (20) drive_cycle();   // quiet tail, stray beats trip the monitor
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* agg_datapath.f */
src/agg_pkg.sv
src/credit_fifo.sv
src/port_align.sv
src/lane_adder.sv
src/egress_sequencer.sv
src/agg_datapath.sv
verif/agg_datapath_tb.sv

/* Makefile */
VERILATOR  := verilator
TOP        := agg_datapath_tb
FILELIST   := agg_datapath.f
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
